/* rv_pkg.sv */
// ------------------------------------------------
// shared types for the rv32i five-stage core
// opcode and branch funct3 constants
// instruction word union with per-format views
// alu and branch enums, pipeline register structs
// ------------------------------------------------
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // base opcodes, only the supported subset
    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_i_alu  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam int dmem_words_default = 64;

    // ------------------------------------------------
    // instruction formats, all 32 bits
    // ------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;     // imm[11:5]
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;     // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // one fetched word, read in every view by decode
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } inst_t;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_or} alu_ctrl_t;
    typedef enum logic [1:0] {br_eq, br_ne, br_lt, br_ge} br_kind_t;

    // ------------------------------------------------
    // pipeline registers
    // ------------------------------------------------
    typedef struct packed {
        word_t pc;
        inst_t inst;
        logic  valid;           // cleared by reset and flush
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        alu_ctrl_t alu_ctrl;
        logic      alu_src;     // 1 = imm as second operand
        logic      use_rs2;
        logic      is_branch;
        br_kind_t  br_kind;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;   // also the load/store address
        word_t    store_data;
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
    } ex_mem_t;

    // regfile write and external report, valid only when rd != 0
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* rv_regfile.sv */
// ------------------------------------------------
// 32-entry register file, x0 reads zero
// write-through read of the index being written
// ------------------------------------------------
module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset_b,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  wb_t      wb,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [1:31];         // no storage for x0

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;     // wb.valid already excludes rd 0
        end
    end

    // bypass so decode sees this cycle's writeback
    assign rs1_data = (rs1 == '0) ? '0 : (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

/* rv_fetch.sv */
// ------------------------------------------------
// fetch stage
// program counter with redirect select
// IF/ID register, holds on stall, clears on flush
// ------------------------------------------------
module rv_fetch
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset_b,
    input  logic      stall,
    input  redirect_t redirect,
    output word_t     imem_addr,
    input  inst_t     imem_inst,
    output if_id_t    if_id
);

    word_t pc;
    word_t pc_next;

    assign imem_addr = pc;
    // redirect wins over stall
    assign pc_next = redirect.taken ? redirect.target : pc + 32'd4;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            pc <= '0;
        end else if (redirect.taken || !stall) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            if_id <= '0;
        end else if (redirect.taken) begin
            if_id <= '0;                        // drop the wrong-path fetch
        end else if (!stall) begin
            if_id <= '{pc: pc, inst: imem_inst, valid: 1'b1};
        end
    end

endmodule

/* rv_decode.sv */
// ------------------------------------------------
// decode stage
// control decode and immediate generation
// load-use hazard detection, register file
// ID/EX register with bubble and flush
// ------------------------------------------------
module rv_decode
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset_b,
    input  if_id_t    if_id,
    input  redirect_t redirect,
    input  wb_t       wb,
    output id_ex_t    id_ex,
    output logic      stall
);

    inst_t  inst;
    word_t  rs1_data;
    word_t  rs2_data;
    id_ex_t dec;                // next ID/EX contents
    logic   legal;              // supported opcode in a valid slot

    // funct3 to alu op, sub only when the caller says so
    function automatic alu_ctrl_t alu_of(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b111:  return alu_and;
            3'b110:  return alu_or;
            default: return sub ? alu_sub : alu_add;
        endcase
    endfunction

    assign inst = if_id.inst;

    rv_regfile u_regfile (
        .clk      (clk),
        .reset_b  (reset_b),
        .rs1      (inst.r_fmt.rs1),
        .rs2      (inst.r_fmt.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ------------------------------------------------
    // control and immediates
    // ------------------------------------------------
    always_comb begin
        dec   = '0;
        legal = 1'b0;
        if (if_id.valid) begin
            case (inst.r_fmt.opcode)
                op_r_type: begin
                    legal         = 1'b1;
                    dec.use_rs2   = 1'b1;
                    dec.reg_write = 1'b1;
                    dec.alu_ctrl  = alu_of(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
                end
                op_i_alu: begin
                    legal         = 1'b1;
                    dec.alu_src   = 1'b1;
                    dec.reg_write = 1'b1;
                    dec.alu_ctrl  = alu_of(inst.i_fmt.funct3, 1'b0);   // no subi
                    dec.imm       = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                end
                op_load: begin
                    legal         = 1'b1;
                    dec.alu_src   = 1'b1;
                    dec.mem_read  = 1'b1;
                    dec.reg_write = 1'b1;
                    dec.imm       = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                end
                op_store: begin
                    legal         = 1'b1;
                    dec.alu_src   = 1'b1;
                    dec.use_rs2   = 1'b1;   // store data
                    dec.mem_write = 1'b1;
                    dec.imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
                end
                op_branch: begin
                    legal         = 1'b1;
                    dec.use_rs2   = 1'b1;
                    dec.is_branch = 1'b1;
                    dec.br_kind   = br_kind_t'({inst.b_fmt.funct3[2], inst.b_fmt.funct3[0]});
                    // offset in half-words, low bit always zero
                    dec.imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                               inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
                end
                default: legal = 1'b0;  // unknown opcode, stays a bubble
            endcase
        end
        if (legal) begin
            dec.pc       = if_id.pc;
            dec.rs1      = inst.r_fmt.rs1;
            dec.rs2      = inst.r_fmt.rs2;
            dec.rd       = inst.r_fmt.rd;
            dec.rs1_data = rs1_data;
            dec.rs2_data = rs2_data;
        end
    end

    // load in EX feeding this instruction, one bubble
    assign stall = legal && id_ex.mem_read &&
                   ((id_ex.rd == dec.rs1) || (dec.use_rs2 && (id_ex.rd == dec.rs2)));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            id_ex <= '0;
        end else if (redirect.taken || stall) begin
            id_ex <= '0;        // flush or bubble
        end else begin
            id_ex <= dec;
        end
    end

endmodule

/* rv_execute.sv */
// ------------------------------------------------
// execute stage
// operand forwarding from EX/MEM and MEM/WB
// alu, branch unit and redirect
// EX/MEM register
// ------------------------------------------------
module rv_execute
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset_b,
    input  id_ex_t    id_ex,
    input  wb_t       wb,
    output ex_mem_t   ex_mem,
    output redirect_t redirect
);

    word_t       op_a;          // forwarded rs1
    word_t       op_b_reg;      // forwarded rs2, also store data
    word_t       op_b;          // alu second operand
    word_t       alu_y;
    logic [32:0] diff;          // sign-extended a - b
    logic        is_eq;
    logic        is_lt;
    logic        br_cond;

    // ------------------------------------------------
    // forwarding, EX/MEM first then wb
    // ------------------------------------------------
    always_comb begin
        op_a = id_ex.rs1_data;
        if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == id_ex.rs1) begin
            op_a = ex_mem.alu_result;
        end else if (wb.valid && wb.rd == id_ex.rs1) begin
            op_a = wb.data;
        end
    end

    always_comb begin
        op_b_reg = id_ex.rs2_data;
        if (id_ex.use_rs2) begin
            if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == id_ex.rs2) begin
                op_b_reg = ex_mem.alu_result;
            end else if (wb.valid && wb.rd == id_ex.rs2) begin
                op_b_reg = wb.data;
            end
        end
    end

    assign op_b = id_ex.alu_src ? id_ex.imm : op_b_reg;

    // alu
    always_comb begin
        case (id_ex.alu_ctrl)
            alu_sub: alu_y = op_a - op_b;
            alu_and: alu_y = op_a & op_b;
            alu_or:  alu_y = op_a | op_b;
            default: alu_y = op_a + op_b;
        endcase
    end

    // ------------------------------------------------
    // branch unit
    // ------------------------------------------------
    assign diff  = {op_a[31], op_a} - {op_b_reg[31], op_b_reg};
    assign is_eq = (diff == '0);
    assign is_lt = diff[32];            // true sign, no overflow in 33 bits

    always_comb begin
        case (id_ex.br_kind)
            br_eq:   br_cond = is_eq;
            br_ne:   br_cond = !is_eq;
            br_lt:   br_cond = is_lt;
            default: br_cond = !is_lt;  // bge
        endcase
    end

    assign redirect.taken  = id_ex.is_branch && br_cond;
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= op_b_reg;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
        end
    end

endmodule

/* rv_memory.sv */
// ------------------------------------------------
// memory stage
// word-wide data memory, zeroed at reset
// MEM/WB register and writeback select
// ------------------------------------------------
module rv_memory
    import rv_pkg::*;
#(
    parameter int dmem_words = dmem_words_default
) (
    input  logic    clk,
    input  logic    reset_b,
    input  ex_mem_t ex_mem,
    output wb_t     wb
);

    localparam int idx_w = (dmem_words > 1) ? $clog2(dmem_words) : 1;

    word_t            dmem [dmem_words];
    word_t            word_addr;        // byte address >> 2
    logic [idx_w-1:0] idx;

    assign word_addr = ex_mem.alu_result >> 2;
    assign idx       = idx_w'(word_addr % word_t'(dmem_words));  // wraps at depth

    // write on the edge the store leaves EX/MEM
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.mem_write) begin
            dmem[idx] <= ex_mem.store_data;
        end
    end

    // MEM/WB, load data or alu result
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wb <= '0;
        end else begin
            wb.valid <= ex_mem.reg_write && (ex_mem.rd != '0);   // x0 writes never show
            wb.rd    <= ex_mem.rd;
            wb.data  <= ex_mem.mem_read ? dmem[idx] : ex_mem.alu_result;
        end
    end

endmodule

/* rv_core.sv */
// ------------------------------------------------
// rv32i five-stage pipeline, top level
// fetch port out to the program store
// writeback report out of the memory stage
// ------------------------------------------------
module rv_core
    import rv_pkg::*;
#(
    parameter int dmem_words = dmem_words_default  // data memory depth in words
) (
    input  logic  clk,
    input  logic  reset_b,
    output word_t imem_addr,    // byte pc
    input  inst_t imem_inst,    // returned in the same cycle
    output wb_t   wb
);

    // stage links
    logic      stall;           // load-use, from decode
    redirect_t redirect;        // taken branch, from execute
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;

    rv_fetch u_fetch (
        .clk       (clk),
        .reset_b   (reset_b),
        .stall     (stall),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_inst (imem_inst),
        .if_id     (if_id)
    );

    rv_decode u_decode (
        .clk      (clk),
        .reset_b  (reset_b),
        .if_id    (if_id),
        .redirect (redirect),
        .wb       (wb),         // regfile write port
        .id_ex    (id_ex),
        .stall    (stall)
    );

    rv_execute u_execute (
        .clk      (clk),
        .reset_b  (reset_b),
        .id_ex    (id_ex),
        .wb       (wb),         // second forwarding source
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    rv_memory #(
        .dmem_words (dmem_words)
    ) u_memory (
        .clk     (clk),
        .reset_b (reset_b),
        .ex_mem  (ex_mem),
        .wb      (wb)
    );

endmodule

/* rv_core_asserts.sv */
// ------------------------------------------------
// concurrent checks on rv_core pipeline control
// writeback rd, pc step, quiet wb during reset
// bind into rv_core
// ------------------------------------------------
module rv_core_asserts
    import rv_pkg::*;
(
    input logic      clk,
    input logic      reset_b,
    input word_t     imem_addr,
    input logic      stall,
    input redirect_t redirect,
    input wb_t       wb
);

    // a reported writeback always names a real register
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!reset_b)
        wb.valid |-> wb.rd != '0)
        else $error("writeback reported with rd x0");

    // sequential pc when nothing holds or redirects it
    pc_step: assert property (@(posedge clk) disable iff (!reset_b)
        reset_b && !stall && !redirect.taken |=> imem_addr == $past(imem_addr) + 32'd4)
        else $error("pc did not advance by four");

    no_wb_in_reset: assert property (@(posedge clk)
        !reset_b |-> !wb.valid)
        else $error("writeback reported during reset");

endmodule

bind rv_core rv_core_asserts u_asserts (
    .clk       (clk),
    .reset_b   (reset_b),
    .imem_addr (imem_addr),
    .stall     (stall),
    .redirect  (redirect),
    .wb        (wb)
);

/* tb_rv_core.sv */
// ------------------------------------------------
// testbench for the rv32i pipeline core
// random program generator and encoder
// instruction-set reference model
// clock, reset, writeback compare and timeout
// ------------------------------------------------
module tb_rv_core
    import rv_pkg::*;
();

    localparam int    n_prog     = 200;
    localparam int    n_pad      = 4;       // trailing no-ops
    localparam int    dmem_depth = 64;
    localparam int    max_cycles = 4 * n_prog + 50;     // 4 cycles per instruction plus fill
    localparam word_t nop_word   = {12'd0, 5'd0, 3'b000, 5'd0, op_i_alu};

    typedef enum logic [3:0] {
        k_add, k_sub, k_and, k_or, k_addi, k_lw, k_sw, k_beq, k_bne, k_blt, k_bge
    } kind_t;

    // one program slot as the generator sees it
    typedef struct packed {
        kind_t    kind;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
    } op_t;

    logic  clk;
    logic  reset_b;
    word_t imem_addr;
    inst_t imem_inst;
    wb_t   wb;

    op_t         prog_op [n_prog];
    word_t       prog_word [n_prog];
    logic [31:0] rng;
    word_t       m_pc;                      // model state
    word_t       m_regs [32];
    word_t       m_mem [dmem_depth];
    wb_t         pending;                   // next expected writeback
    int          n_checked;
    int          cycles;
    logic        done;

    rv_core #(
        .dmem_words (dmem_depth)
    ) dut0 (
        .clk       (clk),
        .reset_b   (reset_b),
        .imem_addr (imem_addr),
        .imem_inst (imem_inst),
        .wb        (wb)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ------------------------------------------------
    // program generation, encoding per the ISA
    // ------------------------------------------------
    function automatic word_t encode(input op_t op);
        logic [12:0] b;
        logic [2:0]  f3;
        b = op.imm[12:0];
        case (op.kind)
            k_beq:   f3 = f3_beq;
            k_bne:   f3 = f3_bne;
            k_blt:   f3 = f3_blt;
            default: f3 = f3_bge;
        endcase
        case (op.kind)
            k_add:   return {7'h00, op.rs2, op.rs1, 3'b000, op.rd, op_r_type};
            k_sub:   return {7'h20, op.rs2, op.rs1, 3'b000, op.rd, op_r_type};
            k_and:   return {7'h00, op.rs2, op.rs1, 3'b111, op.rd, op_r_type};
            k_or:    return {7'h00, op.rs2, op.rs1, 3'b110, op.rd, op_r_type};
            k_addi:  return {op.imm[11:0], op.rs1, 3'b000, op.rd, op_i_alu};
            k_lw:    return {op.imm[11:0], op.rs1, 3'b010, op.rd, op_load};
            k_sw:    return {op.imm[11:5], op.rs2, op.rs1, 3'b010, op.imm[4:0], op_store};
            default: return {b[12], b[10:5], op.rs2, op.rs1, f3, b[4:1], b[11], op_branch};
        endcase
    endfunction

    task automatic build_program();
        op_t op;
        for (int i = 0; i < n_prog; i++) begin
            rng     = xorshift(rng);
            op.kind = kind_t'(rng[3:0] % 4'd11);    // alu ops come up twice as often
            op.rd   = {2'b00, rng[6:4]};            // x0..x7
            op.rs1  = {2'b00, rng[9:7]};
            op.rs2  = {2'b00, rng[12:10]};
            op.imm  = {{20{rng[24]}}, rng[24:13]};
            if (op.kind == k_lw || op.kind == k_sw) begin
                op.rs1 = '0;                        // base x0
                op.imm = {24'd0, rng[18:13], 2'b00};
            end else if (op.kind >= k_beq) begin
                op.imm = rng[25] ? 32'd12 : 32'd8;  // forward skip of 1 or 2
            end
            if (i >= n_prog - n_pad) begin
                op.kind = k_addi;
                op.rd   = '0;
                op.rs1  = '0;
                op.imm  = '0;
            end
            prog_op[i]   = op;
            prog_word[i] = encode(op);
        end
    endtask

    function automatic inst_t fetch_word(input word_t addr);
        if ((addr >> 2) < word_t'(n_prog)) begin
            return inst_t'(prog_word[int'(addr >> 2)]);
        end else begin
            return inst_t'(nop_word);
        end
    endfunction

    // program store answers the fetch address
    always @(imem_addr) imem_inst <= fetch_word(imem_addr);

    // ------------------------------------------------
    // reference model
    // ------------------------------------------------
    task automatic model_reset();
        m_pc = '0;
        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_mem[i]) m_mem[i] = '0;
    endtask

    function automatic wb_t model_next();
        wb_t   res;
        op_t   op;
        word_t a;
        word_t b;
        word_t v;
        word_t addr;
        res = '0;
        while (!res.valid && m_pc < word_t'(4 * n_prog)) begin
            op   = prog_op[int'(m_pc >> 2)];
            a    = m_regs[op.rs1];
            b    = m_regs[op.rs2];
            addr = a + op.imm;
            v    = '0;
            m_pc = m_pc + 32'd4;
            case (op.kind)
                k_add:  v = a + b;
                k_sub:  v = a - b;
                k_and:  v = a & b;
                k_or:   v = a | b;
                k_addi: v = a + op.imm;
                k_lw:   v = m_mem[addr[7:2]];       // word index mod 64
                k_sw:   m_mem[addr[7:2]] = b;
                k_beq:  if (a == b) m_pc = m_pc - 32'd4 + op.imm;
                k_bne:  if (a != b) m_pc = m_pc - 32'd4 + op.imm;
                k_blt:  if ($signed(a) < $signed(b)) m_pc = m_pc - 32'd4 + op.imm;
                default: if ($signed(a) >= $signed(b)) m_pc = m_pc - 32'd4 + op.imm;
            endcase
            if (op.kind <= k_lw && op.rd != '0) begin
                m_regs[op.rd] = v;
                res = '{valid: 1'b1, rd: op.rd, data: v};
            end
        end
        return res;
    endfunction

    // ------------------------------------------------
    // checking
    // ------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        string exp_s;
        string act_s;
        exp_s = $sformatf("valid %0b rd x%0d data %h", exp.valid, exp.rd, exp.data);
        act_s = $sformatf("valid %0b rd x%0d data %h", act.valid, act.rd, act.data);
        if (act !== exp) begin
            fail_run({"Fail ", name, " expected ", exp_s, " actual ", act_s});
        end
    endtask

    always @(posedge clk) begin
        if (reset_b && wb.valid) begin
            if (done) begin
                fail_run("a writeback arrived after the last one the model expects");
            end else begin
                check_wb($sformatf("writeback %0d", n_checked), pending, wb);
                n_checked++;
                pending = model_next();
                if (!pending.valid) done = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            fail_run("timeout, the core did not finish the program within the cycle limit");
        end
    end

    initial begin
        clk       = 1'b0;
        reset_b   = 1'b0;
        rng       = 32'h2f444e0c;
        n_checked = 0;
        cycles    = 0;
        build_program();
        imem_inst = fetch_word(imem_addr);
        model_reset();
        pending = model_next();
        done    = !pending.valid;
        repeat (5) @(posedge clk);
        reset_b <= 1'b1;
        wait (done);
        repeat (8) @(posedge clk);          // a stray late writeback still gets caught
        $display("All tests passed");
        $finish;
    end

endmodule

/* tb.f */
rv_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_core
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
